//--- src/atariVideo_defs.svh
/*
 * Display path sizes
 * Frame length, bus widths and the pixel clock division
 */
`ifndef ATARIVIDEO_DEFS_SVH
`define ATARIVIDEO_DEFS_SVH

// Words in one frame, cut down for simulation
`define FRAME_WORDS 256
`define FB_ADDR_BITS 8

`define PIXEL_BITS 32     // One display buffer word
`define AXI_ADDR_BITS 16  // Byte address on the write port

// USER_CLK cycles per pixel tick
`define PIXEL_DIV 4

`endif

//--- src/atariVideoPkg.sv
/*
 * Display path types
 * Buffer words, AXI4-Lite write channel bundles and the video stream
 */
`default_nettype none
`include "atariVideo_defs.svh"

package atariVideoPkg;

    typedef logic [`PIXEL_BITS-1:0] pixelWord_t;
    typedef logic [`FB_ADDR_BITS-1:0] fbAddr_t;

    // Only the two codes the writer can return
    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2
    } axiResp_t;

    // Master side of the write channels
    typedef struct packed {
        logic                      awValid;
        logic [`AXI_ADDR_BITS-1:0] awAddr;
        logic                      wValid;
        pixelWord_t                wData;
        logic                      bReady;
    } axiWrReq_t;

    typedef struct packed {
        logic     awReady;
        logic     wReady;
        logic     bValid;
        axiResp_t bResp;
    } axiWrRsp_t;

    typedef struct packed {
        fbAddr_t    addr;
        pixelWord_t data;
    } fbWrite_t;

    typedef struct packed {
        logic       pixelValid;
        logic       frameStart;  // With the word from address 0
        pixelWord_t pixel;
    } videoOut_t;

endpackage

`default_nettype wire

//--- src/displayWriter.sv
/*
 * Display buffer writer
 * Write-only AXI4-Lite slave, turns full-word writes into buffer writes
 * and answers SLVERR for misaligned or out-of-frame addresses
 */
`default_nettype none
`include "atariVideo_defs.svh"

module displayWriter (
    input  logic                     USER_CLK,
    input  logic                     nRES_L,
    input  atariVideoPkg::axiWrReq_t axiReq,
    output atariVideoPkg::axiWrRsp_t axiRsp,
    output logic                     fbWrEn,
    output atariVideoPkg::fbWrite_t  fbWr
);

    // First byte address past the frame
    localparam logic [`AXI_ADDR_BITS-1:0] AddrLimit = `AXI_ADDR_BITS'(4 * `FRAME_WORDS);

    logic                      awFull;
    logic                      wFull;
    logic [`AXI_ADDR_BITS-1:0] awAddrQ;
    atariVideoPkg::pixelWord_t wDataQ;
    logic                      bValid;
    atariVideoPkg::axiResp_t   bResp;

    logic awReady;
    logic wReady;
    logic awFire;
    logic wFire;
    logic resolve;
    logic addrOk;

    // Readies stay low while a response is pending
    assign awReady = !awFull && !bValid;
    assign wReady  = !wFull && !bValid;

    assign awFire  = axiReq.awValid && awReady;
    assign wFire   = axiReq.wValid && wReady;
    assign resolve = awFull && wFull;  // Both halves of a write are held

    // Word aligned and inside the frame
    assign addrOk = (awAddrQ[1:0] == 2'b00) && (awAddrQ < AddrLimit);

    always_ff @(posedge USER_CLK or posedge nRES_L) begin
        if (nRES_L) begin
            awFull <= 1'b0;
            wFull  <= 1'b0;
            bValid <= 1'b0;
            bResp  <= atariVideoPkg::OKAY;
            fbWrEn <= 1'b0;
        end else begin
            fbWrEn <= resolve && addrOk;
            if (resolve) begin
                awFull <= 1'b0;
                wFull  <= 1'b0;
                bValid <= 1'b1;
                if (addrOk) begin
                    bResp <= atariVideoPkg::OKAY;
                end else begin
                    bResp <= atariVideoPkg::SLVERR;
                end
            end else begin
                if (awFire) begin
                    awFull <= 1'b1;
                end
                if (wFire) begin
                    wFull <= 1'b1;
                end
                if (bValid && axiReq.bReady) begin
                    bValid <= 1'b0;  // Response taken
                end
            end
        end
    end

    // Held address and data, then the buffer write itself
    always_ff @(posedge USER_CLK) begin
        if (awFire) begin
            awAddrQ <= axiReq.awAddr;
        end
        if (wFire) begin
            wDataQ <= axiReq.wData;
        end
        if (resolve) begin
            fbWr.addr <= awAddrQ[`FB_ADDR_BITS+1:2];  // Byte to word address
            fbWr.data <= wDataQ;
        end
    end

    assign axiRsp.awReady = awReady;
    assign axiRsp.wReady  = wReady;
    assign axiRsp.bValid  = bValid;
    assign axiRsp.bResp   = bResp;

endmodule

`default_nettype wire

//--- src/frameBuffer.sv
/*
 * Display block memory
 * Simple dual-port RAM, one write port and one registered read port
 */
`default_nettype none
`include "atariVideo_defs.svh"

module frameBuffer #(
    parameter type payload_t = atariVideoPkg::pixelWord_t,
    parameter int  Depth     = `FRAME_WORDS
) (
    input  logic                   USER_CLK,
    input  logic                   wrEn,
    input  atariVideoPkg::fbAddr_t wrAddr,
    input  payload_t               wrData,
    input  logic                   rdEn,
    input  atariVideoPkg::fbAddr_t rdAddr,
    output payload_t               rdData
);

    payload_t mem [Depth];

    always_ff @(posedge USER_CLK) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // Read data appears one cycle after rdEn
    always_ff @(posedge USER_CLK) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

`default_nettype wire

//--- src/scanoutReader.sv
/*
 * Scanout reader
 * Divides USER_CLK down to a pixel tick, walks the frame in a wrapping
 * order and tags each returned word for the video stream
 */
`default_nettype none
`include "atariVideo_defs.svh"

module scanoutReader (
    input  logic                      USER_CLK,
    input  logic                      nRES_L,
    output logic                      rdEn,
    output atariVideoPkg::fbAddr_t    rdAddr,
    input  atariVideoPkg::pixelWord_t rdData,
    output atariVideoPkg::videoOut_t  video
);

    localparam int DivBits = $clog2(`PIXEL_DIV);

    logic [DivBits-1:0]     divCnt;
    logic                   tick;
    atariVideoPkg::fbAddr_t scanAddr;
    logic                   pixelValidQ;
    logic                   frameStartQ;

    assign tick = (divCnt == DivBits'(`PIXEL_DIV - 1));

    // Pixel clock divider
    always_ff @(posedge USER_CLK or posedge nRES_L) begin
        if (nRES_L) begin
            divCnt <= '0;
        end else if (tick) begin
            divCnt <= '0;
        end else begin
            divCnt <= divCnt + 1'b1;
        end
    end

    // Read address, wraps at the frame end
    always_ff @(posedge USER_CLK or posedge nRES_L) begin
        if (nRES_L) begin
            scanAddr <= '0;
        end else if (tick) begin
            if (scanAddr == atariVideoPkg::fbAddr_t'(`FRAME_WORDS - 1)) begin
                scanAddr <= '0;
            end else begin
                scanAddr <= scanAddr + 1'b1;
            end
        end
    end

    // Flags line up with the buffer's read latency
    always_ff @(posedge USER_CLK or posedge nRES_L) begin
        if (nRES_L) begin
            pixelValidQ <= 1'b0;
            frameStartQ <= 1'b0;
        end else begin
            pixelValidQ <= tick;
            frameStartQ <= tick && (scanAddr == '0);
        end
    end

    assign rdEn   = tick;
    assign rdAddr = scanAddr;

    assign video.pixelValid = pixelValidQ;
    assign video.frameStart = frameStartQ;
    assign video.pixel      = rdData;  // Held by the buffer between reads

endmodule

`default_nettype wire

//--- src/atariVideoTop.sv
/*
 * Display path top
 * AXI4-Lite writer into the display buffer, scanout reading it back
 */
`default_nettype none
`include "atariVideo_defs.svh"

module atariVideoTop (
    input  logic                     USER_CLK,
    input  logic                     nRES_L,
    input  atariVideoPkg::axiWrReq_t axiReq,
    output atariVideoPkg::axiWrRsp_t axiRsp,
    output atariVideoPkg::videoOut_t video
);

    logic                      fbWrEn;
    atariVideoPkg::fbWrite_t   fbWr;
    logic                      rdEn;
    atariVideoPkg::fbAddr_t    rdAddr;
    atariVideoPkg::pixelWord_t rdData;

    displayWriter writer (
        .USER_CLK (USER_CLK),
        .nRES_L   (nRES_L),
        .axiReq   (axiReq),
        .axiRsp   (axiRsp),
        .fbWrEn   (fbWrEn),
        .fbWr     (fbWr)
    );

    frameBuffer #(
        .payload_t (atariVideoPkg::pixelWord_t),
        .Depth     (`FRAME_WORDS)
    ) displayMem (
        .USER_CLK (USER_CLK),
        .wrEn     (fbWrEn),
        .wrAddr   (fbWr.addr),
        .wrData   (fbWr.data),
        .rdEn     (rdEn),
        .rdAddr   (rdAddr),
        .rdData   (rdData)
    );

    scanoutReader scanout (
        .USER_CLK (USER_CLK),
        .nRES_L   (nRES_L),
        .rdEn     (rdEn),
        .rdAddr   (rdAddr),
        .rdData   (rdData),
        .video    (video)
    );

endmodule

`default_nettype wire

//--- verif/atariVideo_sva.sv
/*
 * Write handshake and scanout timing checks
 * Bound into the writer and the scanout reader
 */
`default_nettype none
`include "atariVideo_defs.svh"

module atariVideoSva (
    input logic                     USER_CLK,
    input logic                     nRES_L,
    input atariVideoPkg::axiWrRsp_t rsp,
    input logic                     bReady,
    input logic                     pixelValid
);

    // Response held under back-pressure
    assert property (@(posedge USER_CLK) disable iff (nRES_L)
        rsp.bValid && !bReady |=> rsp.bValid && $stable(rsp.bResp))
        else $error("bValid or bResp changed before bReady");

    assert property (@(posedge USER_CLK) disable iff (nRES_L)
        rsp.bValid |-> !rsp.awReady && !rsp.wReady)
        else $error("ready high while a response is pending");

    assert property (@(posedge USER_CLK) disable iff (nRES_L)
        pixelValid |=> !pixelValid [*(`PIXEL_DIV - 1)] ##1 pixelValid)
        else $error("pixelValid pulses not PIXEL_DIV cycles apart");

endmodule

bind displayWriter atariVideoSva writerChecks (
    .USER_CLK   (USER_CLK),
    .nRES_L     (nRES_L),
    .rsp        (axiRsp),
    .bReady     (axiReq.bReady),
    .pixelValid (1'b0)
);

bind scanoutReader atariVideoSva scanoutChecks (
    .USER_CLK   (USER_CLK),
    .nRES_L     (nRES_L),
    .rsp        ('0),
    .bReady     (1'b0),
    .pixelValid (video.pixelValid)
);

`default_nettype wire

//--- verif/atariVideoTb.sv
/*
 * Display path testbench
 * File-driven AXI4-Lite writes, then one scanned frame compared with a model
 */
`default_nettype none
`include "atariVideo_defs.svh"

module atariVideoTb;

    logic                      USER_CLK;
    logic                      nRES_L;
    atariVideoPkg::axiWrReq_t  axiReq;
    atariVideoPkg::axiWrRsp_t  axiRsp;
    atariVideoPkg::videoOut_t  video;
    atariVideoPkg::pixelWord_t model [`FRAME_WORDS];
    logic                      written [`FRAME_WORDS];
    int opQ [$];
    int addrQ [$];
    int dataQ [$];
    int respQ [$];
    int holdQ [$];
    int valueErrors = 0;
    int otherErrors = 0;
    int seed = 73539;
    int pulseCnt = 0;
    int sinceLast = 0;
    int frameIdx = 0;
    logic loaded = 1'b0;
    logic frameArmed = 1'b0;
    logic frameActive = 1'b0;
    logic frameDone = 1'b0;

    atariVideoTop DUT (
        .USER_CLK (USER_CLK),
        .nRES_L   (nRES_L),
        .axiReq   (axiReq),
        .axiRsp   (axiRsp),
        .video    (video)
    );

    always #2 USER_CLK = ~USER_CLK;

    // Inputs move 1 unit after the rising edge
    task automatic step();
        @(posedge USER_CLK);
        #1;
    endtask

    task automatic protocolError(input string what);
        $display("at %0t: %s", $time, what);
        otherErrors++;
    endtask

    task automatic runWrite(input int op, input int addr, input int data, input int resp,
                            input int hold);
        logic awPend;
        logic wPend;
        logic awTaken;
        logic wTaken;
        awPend = 1'b1;
        wPend  = 1'b1;
        axiReq.awAddr = 16'(addr);
        axiReq.wData  = 32'(data);
        while (awPend || wPend) begin
            axiReq.awValid = awPend && (op != 1 || !wPend);  // Op 0 AW first, op 1 W first
            axiReq.wValid  = wPend && (op != 0 || !awPend);
            awTaken = axiReq.awValid && axiRsp.awReady;
            wTaken  = axiReq.wValid && axiRsp.wReady;
            step();
            if (awTaken) awPend = 1'b0;
            if (wTaken) wPend = 1'b0;
        end
        axiReq.awValid = 1'b0;
        axiReq.wValid  = 1'b0;
        while (!axiRsp.bValid) step();
        if (axiRsp.bResp !== 2'(resp)) begin
            $display("error at %0t: bResp expected %0h, got %0h", $time, resp, axiRsp.bResp);
            valueErrors++;
        end
        repeat (hold) begin  // bReady held low
            step();
            if (!axiRsp.bValid)
                protocolError("response dropped while bReady was low");
            if (axiRsp.bResp !== 2'(resp)) begin
                $display("error at %0t: bResp expected %0h, got %0h",
                         $time, resp, axiRsp.bResp);
                valueErrors++;
            end
            if (axiRsp.awReady || axiRsp.wReady)
                protocolError("a ready was high while a response was pending");
        end
        axiReq.bReady = 1'b1;
        step();
        axiReq.bReady = 1'b0;
        if (axiRsp.bValid) protocolError("bValid still high after the response was taken");
        if (resp == 0) begin
            model[(addr >> 2) % `FRAME_WORDS]   = 32'(data);
            written[(addr >> 2) % `FRAME_WORDS] = 1'b1;
        end
    endtask

    // Scanout monitor, pulse spacing, frame marker and the frame compare
    always @(posedge USER_CLK) begin
        #1;
        if (!nRES_L) begin
            sinceLast++;
            if (video.frameStart && !video.pixelValid) protocolError("frameStart without pixelValid");
            if (video.pixelValid) begin
                if (pulseCnt > 0 && sinceLast != `PIXEL_DIV) begin
                    $display("error at %0t: pixelValid gap expected %0d, got %0d",
                             $time, `PIXEL_DIV, sinceLast);
                    valueErrors++;
                end
                if (video.frameStart !== (pulseCnt % `FRAME_WORDS == 0)) begin
                    $display("error at %0t: frameStart expected %0b, got %0b",
                             $time, pulseCnt % `FRAME_WORDS == 0, video.frameStart);
                    valueErrors++;
                end
                if (video.frameStart && frameArmed) begin
                    frameArmed  = 1'b0;
                    frameActive = 1'b1;
                    frameIdx    = 0;
                end
                if (frameActive) begin
                    if (written[frameIdx] && video.pixel !== model[frameIdx]) begin
                        $display("error at %0t: pixel[%0d] expected %h, got %h",
                                 $time, frameIdx, model[frameIdx], video.pixel);
                        valueErrors++;
                    end
                    frameIdx++;
                    frameActive = (frameIdx < `FRAME_WORDS);
                    frameDone   = !frameActive;
                end
                pulseCnt++;
                sinceLast = 0;
            end
        end
    end

    initial begin : mainFlow
        int    fd;
        string line;
        int    op, addr, data, resp, hold;
        USER_CLK = 1'b0;
        nRES_L   = 1'b1;
        axiReq   = '0;
        for (int i = 0; i < `FRAME_WORDS; i++) written[i] = 1'b0;
        fd = $fopen("verif/atariVideo_stimulus.txt", "r");
        if (fd == 0) begin
            protocolError("could not open the stimulus file");
        end else begin
            while ($fgets(line, fd)) begin
                if (line.substr(0, 0) != "#" &&
                    $sscanf(line, "%h %h %h %h %h", op, addr, data, resp, hold) == 5) begin
                    opQ.push_back(op);
                    addrQ.push_back(addr);
                    dataQ.push_back(data);
                    respQ.push_back(resp);
                    holdQ.push_back(hold);
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
        repeat (16) @(posedge USER_CLK);
        #1;
        nRES_L = 1'b0;
        if (!axiRsp.awReady || !axiRsp.wReady) protocolError("readies low after reset");
        if (axiRsp.bValid || video.pixelValid || video.frameStart)
            protocolError("bValid, pixelValid or frameStart high after reset");
        foreach (opQ[i]) begin
            repeat ($random(seed) & 3) step();  // Idle gap of 0 to 3 cycles
            runWrite(opQ[i], addrQ[i], dataQ[i], respQ[i], holdQ[i]);
        end
        frameArmed = 1'b1;
        wait (frameDone);
        $display("Error count: %0d value, %0d other", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (loaded);
        repeat (opQ.size() * 40 + 3 * `FRAME_WORDS * `PIXEL_DIV + 100) @(posedge USER_CLK);
        $display("timeout: the writes and the frame check did not finish in time");
        $display("Error count: %0d value, %0d other", valueErrors, otherErrors);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/atariVideo_stimulus.txt
# op (0 AW first, 1 W first, 2 together), byte address, data, response (0 OKAY, 2 SLVERR),
# cycles bReady is held low; all fields hex
0 0000 11110000 0 0
1 0004 22220001 0 2
2 0008 33330002 0 0
0 0010 44440004 0 3
2 0100 66660040 0 1
1 03fc 555500ff 0 0
0 0004 77770001 0 4
1 0400 dead0400 2 2
0 0012 dead0012 2 0
2 0101 dead0101 2 1
1 1004 dead1004 2 3
2 0402 dead0402 2 0
0 ffff deadffff 2 1
2 0008 88880002 0 5

//--- atariVideo.f
+incdir+src
src/atariVideoPkg.sv
src/displayWriter.sv
src/frameBuffer.sv
src/scanoutReader.sv
src/atariVideoTop.sv
verif/atariVideo_sva.sv
verif/atariVideoTb.sv

//--- Bender.yml
package:
  name: atariVideo

export_include_dirs:
  - src

sources:
  - src/atariVideoPkg.sv
  - src/displayWriter.sv
  - src/frameBuffer.sv
  - src/scanoutReader.sv
  - src/atariVideoTop.sv
  - target: test
    files:
      - verif/atariVideo_sva.sv
      - verif/atariVideoTb.sv
